// ==== inst_rom.hex ====
// One 32-bit instruction word per line, word index 0 at the ROM base.
00000093
00100113
00200193
00300213
00400293
00500313
00600393
00700413
00800493
00900513
00a00593
00b00613
00c00693
00d00713
00e00793
00f00813
01000893
01100913
01200993
01300a13
01400a93
01500b13
01600b93
01700c13
01800c93
01900d13
01a00d93
01b00e13
01c00e93
01d00f13
01e00f93
01f00093
02000113
02100193
02200213
02300293
02400313
02500393
02600413
02700493
02800513
02900593
02a00613
02b00693
02c00713
02d00793
02e00813
02f00893
03000913
03100993
03200a13
03300a93
03400b13
03500b93
03600c13
03700c93
03800d13
03900d93
03a00e13
03b00e93
03c00f13
03d00f93
03e00093
03f00113

// ==== all.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/ifu.sv
hdl/inst_rom.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch testbench with Verilator and runs it from the project root,
# so that the ROM image is found by its relative path.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f all.f --top-module tb_fetch \
    -Mdir obj_dir -o tb_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi

exit 0

// ==== sim/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int EXPECTED_INSTS  = 20 + 2 + 7 + 300;   // Worst case over all tests.
    localparam int WATCHDOG_CYCLES = EXPECTED_INSTS * 200;

    logic  clk;
    logic  rst;
    logic  id_ready;
    logic  redirect;
    addr_t redirect_pc;

    logic  inst_valid;
    word_t inst;
    addr_t inst_pc;
    logic  inst_fault;

    word_t rom_img [ROM_WORDS];
    addr_t exp_pc;
    addr_t last_pc;
    int    accept_count;
    int    checks;
    int    errors;
    int    seed;

    fetch_top DUT (
        .clk         (clk),
        .rst         (rst),
        .id_ready    (id_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_fault  (inst_fault)
    );

    always #5 clk = ~clk;

    function automatic logic in_rom(input addr_t pc);
        return (pc >= ROM_BASE) && (pc < ROM_BASE + addr_t'(ROM_WORDS * 4));
    endfunction

    // Word the decode stage should see for a given PC.
    function automatic word_t model_word(input addr_t pc);
        addr_t off;
        off = pc - ROM_BASE;
        if (!in_rom(pc)) begin
            return '0;
        end
        return rom_img[off[ROM_AW+1:2]];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!inst_valid && n < 10) begin
            step();
            n++;
        end
        assert (inst_valid) else begin
            $display("No instruction was presented within %0d cycles", n);
            errors++;
        end
    endtask

    task automatic wait_accepts(input int count);
        int target;
        int n;
        target = accept_count + count;
        n = 0;
        while (accept_count < target && n < count * 10) begin
            step();
            n++;
        end
        assert (accept_count >= target) else begin
            $display("Only %0d of %0d instructions were accepted in time",
                     count - (target - accept_count), count);
            errors++;
        end
    endtask

    // Every acceptance, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst && !inst_valid) begin
            check_value("inst while idle", inst, 32'd0);
        end
        if (!rst && inst_valid && id_ready) begin
            check_value("inst_pc", inst_pc, exp_pc);
            check_value("inst", inst, model_word(exp_pc));
            check_value("inst_fault", {31'd0, inst_fault}, {31'd0, !in_rom(exp_pc)});
            last_pc = inst_pc;
            exp_pc  = redirect ? redirect_pc : exp_pc + 32'd4;
            accept_count++;
        end
    end

    task automatic sequential_fetch();
        id_ready = 1'b1;
        wait_accepts(20);
    endtask

    task automatic back_pressure_hold();
        word_t held_inst;
        addr_t held_pc;
        id_ready = 1'b0;
        wait_valid();
        held_inst = inst;
        held_pc   = inst_pc;
        repeat (6) begin
            step();
            check_value("inst_valid under stall", {31'd0, inst_valid}, 32'd1);
            check_value("inst under stall", inst, held_inst);
            check_value("inst_pc under stall", inst_pc, held_pc);
        end
        id_ready = 1'b1;
        wait_accepts(2);
        check_value("pc after release", last_pc, held_pc + 32'd4);
    endtask

    // Redirect taken with the instruction now on display, next one checked.
    task automatic jump_and_check(input addr_t target);
        id_ready = 1'b0;
        wait_valid();
        redirect    = 1'b1;
        redirect_pc = target;
        id_ready    = 1'b1;
        step();
        redirect    = 1'b0;
        redirect_pc = '0;
        id_ready    = 1'b0;
        wait_valid();
        check_value("inst_pc after redirect", inst_pc, target);
        check_value("inst after redirect", inst, model_word(target));
        check_value("inst_fault after redirect", {31'd0, inst_fault},
                    {31'd0, !in_rom(target)});
    endtask

    task automatic redirect_jumps();
        jump_and_check(ROM_BASE + 32'h80);
        jump_and_check(ROM_BASE + 32'h10);
        jump_and_check(ROM_BASE + 32'h10);   // Same target again.
    endtask

    task automatic fault_response();
        jump_and_check(ROM_BASE + addr_t'(ROM_WORDS * 4) + 32'h40);
        check_value("fault flag past ROM", {31'd0, inst_fault}, 32'd1);
        check_value("word past ROM", inst, 32'd0);
        jump_and_check(ROM_BASE + 32'h20);
    endtask

    task automatic random_readiness();
        logic [31:0] rnd;
        int          start;
        start = accept_count;
        repeat (300) begin
            rnd         = $random(seed);
            id_ready    = rnd[0];
            redirect    = (rnd[7:4] == 4'd0);
            redirect_pc = ROM_BASE + {24'd0, rnd[13:8], 2'b00};
            step();
        end
        id_ready    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        assert (accept_count - start > 10) else begin
            $display("Random test accepted only %0d instructions", accept_count - start);
            errors++;
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk          = 1'b0;
        rst          = 1'b1;
        id_ready     = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        seed         = 32'ha09f6e7a;
        exp_pc       = RESET_PC;
        last_pc      = '0;
        accept_count = 0;
        checks       = 0;
        errors       = 0;
        $readmemh(ROM_FILE, rom_img);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        sequential_fetch();
        back_pressure_hold();
        redirect_jumps();
        fault_response();
        random_readiness();
        repeat (5) step();

        $display("Checks: %0d, accepted: %0d, errors: %0d", checks, accept_count, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, accepted: %0d, errors: %0d", checks, accept_count, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Decode side.
    input  logic  id_ready,
    input  logic  redirect,
    input  addr_t redirect_pc,

    output logic  inst_valid,
    output word_t inst,
    output addr_t inst_pc,
    output logic  inst_fault
);

    addr_t pc;
    logic  next_inst_flag;

    // Fetch bus.
    logic  rd_req;
    addr_t rd_addr;
    word_t rd_data;
    resp_t rd_resp;
    logic  rd_complete;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .id_ready       (id_ready),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .pc             (pc),
        .next_inst_flag (next_inst_flag)
    );

    ifu u_ifu (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .next_inst_flag (next_inst_flag),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_resp        (rd_resp),
        .rd_complete    (rd_complete),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_fault     (inst_fault)
    );

    inst_rom u_inst_rom (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_resp     (rd_resp),
        .rd_complete (rd_complete)
    );

    // PC only moves at acceptance, so it matches the presented word.
    assign inst_pc = pc;

endmodule

// ==== hdl/inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output word_t rd_data,
    output resp_t rd_resp,
    output logic  rd_complete
);

    word_t mem [ROM_WORDS];

    logic       busy;
    logic [1:0] wait_cnt;
    logic [3:0] lfsr;
    logic [3:0] lfsr_next;

    addr_t              addr_q;
    addr_t              offset;
    logic               in_range;
    logic [ROM_AW-1:0]  idx;

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // x^4 + x^3 + 1, period 15.
    assign lfsr_next = {lfsr[2:0], lfsr[3] ^ lfsr[2]};

    // Latency is wait_cnt + 1, so 1 to 4 cycles after the request.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            lfsr     <= 4'b1011;
        end else if (rd_req) begin
            busy     <= 1'b1;
            wait_cnt <= lfsr[1:0];
            lfsr     <= lfsr_next;
        end else if (busy) begin
            if (wait_cnt == 2'd0) begin
                busy <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            addr_q <= rd_addr;
        end
    end

    // Addresses below the base wrap to a large offset and miss as well.
    assign offset   = addr_q - ROM_BASE;
    assign in_range = (offset < addr_t'(ROM_WORDS * 4));
    assign idx      = offset[ROM_AW+1:2];

    assign rd_complete = busy && (wait_cnt == 2'd0);

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        if (rd_complete) begin
            if (in_range) begin
                rd_data = mem[idx];
            end else begin
                rd_resp = RESP_DECERR;
            end
        end
    end

    // Fetch unit waits for acceptance, which needs our completion first.
    a_single_read: assert property (
        @(posedge clk) disable iff (rst)
        rd_req |-> !busy
    ) else $error("inst_rom: request while a read is pending");

endmodule

// ==== hdl/ifu.sv ====
`timescale 1ns/1ps

module ifu
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t pc,
    input  logic  next_inst_flag,

    // Read channel to the ROM.
    output logic  rd_req,
    output addr_t rd_addr,
    input  word_t rd_data,
    input  resp_t rd_resp,
    input  logic  rd_complete,

    // Toward decode.
    output logic  inst_valid,
    output word_t inst,
    output logic  inst_fault
);

    logic  req_q;

    word_t rsp_word;
    logic  rsp_fault;

    logic  buf_valid;
    word_t buf_word;
    logic  buf_fault;

    // Set out of reset so the first fetch goes out without a strobe.
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b1;
        end else begin
            req_q <= next_inst_flag;
        end
    end

    assign rd_req  = req_q;
    assign rd_addr = pc;   // Held by pc_gen until acceptance.

    // Any error response squashes the word.
    assign rsp_fault = (rd_resp != RESP_OKAY);
    assign rsp_word  = rsp_fault ? '0 : rd_data;

    // Holding buffer, filled when decode is not ready in the completion cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (rd_complete && !next_inst_flag) begin
            buf_valid <= 1'b1;
        end else if (next_inst_flag) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_complete && !next_inst_flag) begin
            buf_word  <= rsp_word;
            buf_fault <= rsp_fault;
        end
    end

    assign inst_valid = rd_complete | buf_valid;   // Same cycle as completion.

    assign inst = !inst_valid ? '0
                : buf_valid   ? buf_word
                :               rsp_word;

    assign inst_fault = inst_valid & (buf_valid ? buf_fault : rsp_fault);

    // Only one read in flight, so a full buffer means the slave is idle.
    a_no_cpl_when_full: assert property (
        @(posedge clk) disable iff (rst)
        buf_valid |-> !rd_complete
    ) else $error("ifu: completion while buffer holds an instruction");

endmodule

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  inst_valid,
    input  logic  id_ready,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output addr_t pc,
    output logic  next_inst_flag
);

    addr_t pc_seq;
    addr_t pc_next;

    // Decode stage takes the instruction.
    assign next_inst_flag = inst_valid & id_ready;

    assign pc_seq = pc + 32'd4;

    // Redirect target replaces the sequential PC, sampled at acceptance only.
    always_comb begin
        pc_next = pc;
        if (next_inst_flag) begin
            if (redirect) begin
                pc_next = redirect_pc;
            end else begin
                pc_next = pc_seq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Targets come from outside, so alignment is checked here.
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("pc_gen: misaligned pc %h", pc);

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // Address and data words on the fetch bus.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Bus response codes.
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;   // Good read.
    localparam resp_t RESP_DECERR = 2'd3;   // No slave at this address.

    // First fetch address after reset.
    localparam addr_t RESET_PC = 32'h8000_0000;

    // ROM geometry, mapped at the reset vector.
    localparam addr_t ROM_BASE  = RESET_PC;
    localparam int    ROM_WORDS = 64;
    localparam int    ROM_AW    = $clog2(ROM_WORDS);   // Word index width.

    // Image loaded at start-up.
    localparam string ROM_FILE = "inst_rom.hex";

endpackage
